//--- Makefile
# Verilator build and run for the display link testbench

TOP := tb_display_link

.PHONY: all run lint clean

all: run

run:
	verilator --binary --timing --assert -f tb.f --top-module $(TOP) -Mdir obj_dir
	out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "Done: no errors"

lint:
	verilator --lint-only --timing -f tb.f --top-module $(TOP)

clean:
	rm -rf obj_dir

//--- dv/tb_display_link.sv
/*
 * testbench for the two lane display link
 *   clock, reset and msb first serial lane drivers
 *   reference model of framebuffer, brightness, blank and drop count
 *   update watcher with field compares, directed and random tests
 */

`timescale 1ns/1ps
`include "link_defines.svh"

module tb_display_link;

	logic                clk = 1'b0;
	logic                rst_l;
	logic                serial_a;
	logic                serial_b;
	disp_pkg::coord_t    rd_x;
	disp_pkg::coord_t    rd_y;
	disp_pkg::color_t    rd_color;
	disp_pkg::color_t    brightness;
	logic                blank;
	logic                upd_valid;
	logic                upd_lane;
	net_pkg::pkt_kind_e  upd_kind;
	logic [7:0]          drop_count;

	// reference state
	logic [7:0]   model_fb [8][8];
	logic [7:0]   model_bright;
	logic         model_blank;
	logic [7:0]   model_drops;

	// packets whose last bit is on the wire, with lane and finish cycle
	logic [15:0]  q_pkt [$];
	bit           q_lane [$];
	int           q_cyc [$];

	int           cyc;
	int           errors;
	int           upd_count;
	int           sent_count;
	string        test_name;

	display_link_top u_dut (
		.clk        (clk),
		.rst_l      (rst_l),
		.serial_a   (serial_a),
		.serial_b   (serial_b),
		.rd_x       (rd_x),
		.rd_y       (rd_y),
		.rd_color   (rd_color),
		.brightness (brightness),
		.blank      (blank),
		.upd_valid  (upd_valid),
		.upd_lane   (upd_lane),
		.upd_kind   (upd_kind),
		.drop_count (drop_count)
	);

	// 8 ns period
	always #4 clk = ~clk;

	always @(posedge clk) begin
		cyc <= cyc + 1;
	end

	////////////////////////////////////////////////////////////////////////////
	// helpers
	////////////////////////////////////////////////////////////////////////////

	task automatic finish_run();
		$display("errors: %0d", errors);
		if (errors == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	endtask

	task automatic check_value(input string field, input logic [31:0] exp,
		input logic [31:0] act);
		if (exp !== act) begin
			errors++;
			$display("CHECK FAILED test %s %s expected 0x%0h actual 0x%0h",
				test_name, field, exp, act);
		end
	endtask

	// expected effect of one packet on the display model
	function automatic void apply_packet(input logic [15:0] p);
		case (p[15:14])
			2'd0: model_fb[p[10:8]][p[13:11]] = p[7:0];
			2'd1: begin
				if (p[13:8] == 6'd0) begin
					model_bright = p[7:0];
				end else if (p[13:8] == 6'd1) begin
					model_blank = p[0];
				end else begin
					model_drops = model_drops + 8'd1;
				end
			end
			// reserved kinds
			default: model_drops = model_drops + 8'd1;
		endcase
	endfunction

	function automatic logic [15:0] random_packet();
		logic [15:0] p;
		p = 16'($urandom());
		p[15:14] = 2'($urandom_range(0, 3));
		// keep known selectors common
		if (p[15:14] == 2'd1) begin
			p[13:8] = 6'($urandom_range(0, 2));
		end
		return p;
	endfunction

	task automatic drive_bit(input bit lane, input logic b);
		@(posedge clk);
		#1;
		if (lane) begin
			serial_b = b;
		end else begin
			serial_a = b;
		end
	endtask

	// idle zeros, syncword, packet msb first, trailing zeros
	task automatic send_packet(input bit lane, input int idle, input logic [15:0] p);
		logic [23:0] frame;
		frame = {`LINK_SYNCWORD, p};
		repeat (idle) drive_bit(lane, 1'b0);
		for (int i = 23; i >= 0; i--) begin
			drive_bit(lane, frame[i]);
		end
		q_pkt.push_back(p);
		q_lane.push_back(lane);
		q_cyc.push_back(cyc);
		sent_count++;
		// gap lets the lane re-arm before the next syncword
		repeat (4) drive_bit(lane, 1'b0);
	endtask

	task automatic send_random_stream(input bit lane, input int n);
		repeat (n) send_packet(lane, $urandom_range(0, 5), random_packet());
	endtask

	task automatic wait_updates(input int target);
		int waited;
		waited = 0;
		while (upd_count < target && waited < 200) begin
			@(posedge clk);
			waited++;
		end
		if (upd_count < target) begin
			errors++;
			$display("timeout in test %s, the DUT gave no update within 200 cycles",
				test_name);
			finish_run();
		end
	endtask

	task automatic compare_framebuffer();
		for (int y = 0; y < 8; y++) begin
			for (int x = 0; x < 8; x++) begin
				@(posedge clk);
				#1;
				rd_x = 3'(x);
				rd_y = 3'(y);
				@(negedge clk);
				check_value($sformatf("rd_color[%0d][%0d]", y, x),
					32'(model_fb[y][x]), 32'(rd_color));
			end
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// update watcher
	////////////////////////////////////////////////////////////////////////////

	// oldest finish cycle first, lane a on a tie
	always begin : watch_updates
		int           idx;
		logic [15:0]  p;
		bit           l;
		@(posedge clk);
		#1;
		if (rst_l && upd_valid) begin
			if (q_pkt.size() == 0) begin
				errors++;
				$display("the DUT reported an update with no packet sent");
			end else begin
				idx = 0;
				for (int i = 1; i < q_pkt.size(); i++) begin
					if (q_cyc[i] < q_cyc[idx] ||
						(q_cyc[i] == q_cyc[idx] && q_lane[i] < q_lane[idx])) begin
						idx = i;
					end
				end
				p = q_pkt[idx];
				l = q_lane[idx];
				q_pkt.delete(idx);
				q_lane.delete(idx);
				q_cyc.delete(idx);
				apply_packet(p);
				// read back the addressed cell
				rd_x = p[13:11];
				rd_y = p[10:8];
				@(negedge clk);
				check_value("upd_lane", 32'(l), 32'(upd_lane));
				check_value("upd_kind", 32'(p[15:14]), 32'(upd_kind));
				check_value("brightness", 32'(model_bright), 32'(brightness));
				check_value("blank", 32'(model_blank), 32'(blank));
				check_value("drop_count", 32'(model_drops), 32'(drop_count));
				check_value("rd_color", 32'(model_fb[p[10:8]][p[13:11]]), 32'(rd_color));
			end
			upd_count++;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// tests
	////////////////////////////////////////////////////////////////////////////

	initial begin : run_tests
		void'($urandom(32'h52fa84e9));
		rst_l = 1'b0;
		serial_a = 1'b0;
		serial_b = 1'b0;
		rd_x = '0;
		rd_y = '0;
		cyc = 0;
		errors = 0;
		upd_count = 0;
		sent_count = 0;
		test_name = "reset";
		for (int y = 0; y < 8; y++) begin
			for (int x = 0; x < 8; x++) begin
				model_fb[y][x] = 8'h00;
			end
		end
		model_bright = 8'h00;
		model_blank = 1'b0;
		model_drops = 8'h00;
		repeat (10) @(posedge clk);
		#1;
		rst_l = 1'b1;
		// power-up start pulse arms both lanes
		repeat (5) @(posedge clk);

		test_name = "pixel_lane_a";
		send_packet(1'b0, $urandom_range(0, 5), {2'd0, 3'd3, 3'd5, 8'hc3});
		send_packet(1'b0, $urandom_range(0, 5), {2'd0, 3'd0, 3'd0, 8'h11});
		send_packet(1'b0, $urandom_range(0, 5), {2'd0, 3'd7, 3'd7, 8'hfe});
		wait_updates(3);
		compare_framebuffer();

		test_name = "ctrl_lane_b";
		send_packet(1'b1, $urandom_range(0, 5), {2'd1, 6'd0, 8'h5a});
		send_packet(1'b1, $urandom_range(0, 5), {2'd1, 6'd1, 8'h01});
		send_packet(1'b1, $urandom_range(0, 5), {2'd1, 6'h2a, 8'h77});
		send_packet(1'b1, $urandom_range(0, 5), {2'd1, 6'd1, 8'h00});
		wait_updates(7);

		test_name = "reserved_kinds";
		send_packet(1'b0, $urandom_range(0, 5), {2'd2, 14'h1abc});
		send_packet(1'b1, $urandom_range(0, 5), {2'd3, 14'h0f0f});
		send_packet(1'b0, $urandom_range(0, 5), {2'd3, 14'h2222});
		wait_updates(10);
		compare_framebuffer();

		// equal idle counts make both lanes finish on the same edge
		test_name = "same_cycle";
		fork
			send_packet(1'b0, 2, {2'd0, 3'd2, 3'd6, 8'h9d});
			send_packet(1'b1, 2, {2'd1, 6'd0, 8'h3c});
		join
		fork
			send_packet(1'b0, 0, {2'd0, 3'd2, 3'd6, 8'h44});
			send_packet(1'b1, 0, {2'd0, 3'd2, 3'd6, 8'h88});
		join
		wait_updates(14);
		compare_framebuffer();

		test_name = "random_stream";
		fork
			send_random_stream(1'b0, 15);
			send_random_stream(1'b1, 15);
		join
		wait_updates(44);
		check_value("update_count", 32'(sent_count), 32'(upd_count));
		check_value("pending", 32'd0, 32'(q_pkt.size()));
		compare_framebuffer();

		finish_run();
	end

endmodule : tb_display_link

//--- rtl/disp_pkg.sv
/*
 * display side types
 *   pixel color and framebuffer coordinate
 *   control register selectors
 */

`include "link_defines.svh"

package disp_pkg;

	// one framebuffer cell
	typedef logic [7:0] color_t;

	// row or column index
	typedef logic [$clog2(`LINK_FB_DIM)-1:0] coord_t;

	// reg_sel field of a control packet
	typedef logic [5:0] ctrl_sel_t;

	// brightness level register
	localparam ctrl_sel_t CTRL_SEL_BRIGHT = 6'd0;

	// blank flag, lsb of value only
	localparam ctrl_sel_t CTRL_SEL_BLANK = 6'd1;

endpackage : disp_pkg

//--- rtl/display_link_top.sv
/*
 * two lane display link top level
 *   one packet receiver per serial lane
 *   shared display updater with framebuffer read port
 */

`timescale 1ns/1ps
`include "link_defines.svh"

module display_link_top (
	input  logic                clk,
	input  logic                rst_l,
	input  logic                serial_a,
	input  logic                serial_b,
	input  disp_pkg::coord_t    rd_x,
	input  disp_pkg::coord_t    rd_y,
	output disp_pkg::color_t    rd_color,
	output disp_pkg::color_t    brightness,
	output logic                blank,
	output logic                upd_valid,
	output logic                upd_lane,
	output net_pkg::pkt_kind_e  upd_kind,
	output logic [7:0]          drop_count
);

	// receiver to updater
	logic [`LINK_PKT_BITS-1:0]  pkt_a;
	logic [`LINK_PKT_BITS-1:0]  pkt_b;
	logic                       done_a;
	logic                       done_b;
	logic                       start_a;
	logic                       start_b;

	////////////////////////////////////////////////////////////////////////////
	// lanes
	////////////////////////////////////////////////////////////////////////////

	packet_receiver u_rx_a (
		.clk    (clk),
		.rst_l  (rst_l),
		.start  (start_a),
		.serial (serial_a),
		.pkt    (pkt_a),
		.done   (done_a)
	);

	packet_receiver u_rx_b (
		.clk    (clk),
		.rst_l  (rst_l),
		.start  (start_b),
		.serial (serial_b),
		.pkt    (pkt_b),
		.done   (done_b)
	);

	////////////////////////////////////////////////////////////////////////////
	// display side
	////////////////////////////////////////////////////////////////////////////

	display_updater u_upd (
		.clk        (clk),
		.rst_l      (rst_l),
		.pkt_a      (pkt_a),
		.pkt_b      (pkt_b),
		.done_a     (done_a),
		.done_b     (done_b),
		.start_a    (start_a),
		.start_b    (start_b),
		.rd_x       (rd_x),
		.rd_y       (rd_y),
		.rd_color   (rd_color),
		.brightness (brightness),
		.blank      (blank),
		.upd_valid  (upd_valid),
		.upd_lane   (upd_lane),
		.upd_kind   (upd_kind),
		.drop_count (drop_count)
	);

endmodule : display_link_top

//--- rtl/display_updater.sv
/*
 * display updater for two receive lanes
 *   lane arbitration with lane a first and start pulses
 *   packet decode into framebuffer and control registers
 *   update report and dropped packet counter
 */

`timescale 1ns/1ps
`include "link_defines.svh"

module display_updater (
	input  logic                       clk,
	input  logic                       rst_l,
	input  logic [`LINK_PKT_BITS-1:0]  pkt_a,
	input  logic [`LINK_PKT_BITS-1:0]  pkt_b,
	input  logic                       done_a,
	input  logic                       done_b,
	output logic                       start_a,
	output logic                       start_b,
	input  disp_pkg::coord_t           rd_x,
	input  disp_pkg::coord_t           rd_y,
	output disp_pkg::color_t           rd_color,
	output disp_pkg::color_t           brightness,
	output logic                       blank,
	output logic                       upd_valid,
	output logic                       upd_lane,
	output net_pkg::pkt_kind_e         upd_kind,
	output logic [7:0]                 drop_count
);

	// row major, indexed [y][x]
	disp_pkg::color_t    fb [`LINK_FB_DIM][`LINK_FB_DIM];

	logic                armed;
	logic                take_a;
	logic                take_b;
	logic                take;
	logic                ctrl_known;
	logic                drop;
	net_pkg::pkt_u       sel;
	net_pkg::pkt_kind_e  sel_kind;

	////////////////////////////////////////////////////////////////////////////
	// arbitration and start pulses
	////////////////////////////////////////////////////////////////////////////

	// low only in the first cycle out of reset
	always_ff @(posedge clk, negedge rst_l) begin
		if (!rst_l) begin
			armed <= 1'b0;
		end else begin
			armed <= 1'b1;
		end
	end

	// lane a wins a tie
	// the loser keeps done high and is served next cycle
	assign take_a = done_a;
	assign take_b = done_b & !done_a;
	assign take   = take_a | take_b;

	// power-up pulse on both lanes, then re-arm the consumed lane
	assign start_a = !armed | take_a;
	assign start_b = !armed | take_b;

	////////////////////////////////////////////////////////////////////////////
	// decode
	////////////////////////////////////////////////////////////////////////////

	assign sel      = take_a ? pkt_a : pkt_b;
	assign sel_kind = sel.pix.kind;

	assign ctrl_known = (sel.ctrl.reg_sel == disp_pkg::CTRL_SEL_BRIGHT) ||
		(sel.ctrl.reg_sel == disp_pkg::CTRL_SEL_BLANK);

	// reserved kinds and unknown selectors
	assign drop = take && ((sel_kind == net_pkg::KIND_RSVD2) ||
		(sel_kind == net_pkg::KIND_RSVD3) ||
		((sel_kind == net_pkg::KIND_CTRL) && !ctrl_known));

	////////////////////////////////////////////////////////////////////////////
	// display state
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk, negedge rst_l) begin
		if (!rst_l) begin
			for (int y = 0; y < `LINK_FB_DIM; y++) begin
				for (int x = 0; x < `LINK_FB_DIM; x++) begin
					fb[y][x] <= '0;
				end
			end
		end else if (take && (sel_kind == net_pkg::KIND_PIXEL)) begin
			fb[sel.pix.y][sel.pix.x] <= sel.pix.color;
		end
	end

	assign rd_color = fb[rd_y][rd_x];

	always_ff @(posedge clk, negedge rst_l) begin
		if (!rst_l) begin
			brightness <= '0;
			blank      <= 1'b0;
		end else if (take && (sel_kind == net_pkg::KIND_CTRL)) begin
			if (sel.ctrl.reg_sel == disp_pkg::CTRL_SEL_BRIGHT) begin
				brightness <= sel.ctrl.value;
			end else if (sel.ctrl.reg_sel == disp_pkg::CTRL_SEL_BLANK) begin
				blank <= sel.ctrl.value[0];
			end
		end
	end

	// wraps at 255
	always_ff @(posedge clk, negedge rst_l) begin
		if (!rst_l) begin
			drop_count <= '0;
		end else if (drop) begin
			drop_count <= drop_count + 8'd1;
		end
	end

	// report lines the cycle the new state is visible
	always_ff @(posedge clk, negedge rst_l) begin
		if (!rst_l) begin
			upd_valid <= 1'b0;
			upd_lane  <= 1'b0;
			upd_kind  <= net_pkg::KIND_PIXEL;
		end else begin
			upd_valid <= take;
			if (take) begin
				upd_lane <= take_b;
				upd_kind <= sel_kind;
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// checks
	////////////////////////////////////////////////////////////////////////////

	// a lane that loses a tie still holds done and is served next cycle
	a_tie_served: assert property (@(posedge clk) disable iff (!rst_l)
		(armed && done_a && done_b) |=> start_b);

	// a re-armed lane has dropped done by the next cycle
	a_rearm_a: assert property (@(posedge clk) disable iff (!rst_l)
		start_a |=> !done_a);
	a_rearm_b: assert property (@(posedge clk) disable iff (!rst_l)
		start_b |=> !done_b);

endmodule : display_updater

//--- rtl/link_defines.svh
/*
 * serial link constants
 *   syncword value and width
 *   packet width and receive bit counter width
 *   framebuffer side length
 */

`ifndef LINK_DEFINES_SVH
`define LINK_DEFINES_SVH

// syncword sent msb first ahead of each packet
`define LINK_SYNC_BITS 8
// not reachable from the idle zero level
`define LINK_SYNCWORD 8'hB5

// encoded packet on one lane
`define LINK_PKT_BITS 16
`define LINK_CNT_BITS 5

// square framebuffer of 8-bit colors
`define LINK_FB_DIM 8

`endif

//--- rtl/net_pkg.sv
/*
 * link packet types
 *   kind enum carried in the top bits of every packet
 *   pixel and control layouts of a packet word
 *   union giving both views of one received word
 */

package net_pkg;

	// top two bits of every packet word
	typedef enum logic [1:0] {
		KIND_PIXEL = 2'd0,
		KIND_CTRL  = 2'd1,
		KIND_RSVD2 = 2'd2,
		KIND_RSVD3 = 2'd3
	} pkt_kind_e;

	// pixel write to one framebuffer cell
	typedef struct packed {
		pkt_kind_e  kind;
		logic [2:0] x;
		logic [2:0] y;
		logic [7:0] color;
	} pixel_pkt_t;

	// control register write
	typedef struct packed {
		pkt_kind_e  kind;
		logic [5:0] reg_sel;
		logic [7:0] value;
	} ctrl_pkt_t;

	// one received word
	// kind sits in the same bits for both views
	typedef union packed {
		pixel_pkt_t pix;
		ctrl_pkt_t  ctrl;
	} pkt_u;

endpackage : net_pkg

//--- rtl/packet_receiver.sv
/*
 * single lane packet receiver
 *   syncword search after a start pulse
 *   msb first shift of one packet
 *   done level held until the next start
 */

`timescale 1ns/1ps
`include "link_defines.svh"

module packet_receiver (
	input  logic                       clk,
	input  logic                       rst_l,
	input  logic                       start,
	input  logic                       serial,
	output logic [`LINK_PKT_BITS-1:0]  pkt,
	output logic                       done
);

	logic                        listen;
	logic                        synced;
	logic                        sync_shift;
	logic                        data_shift;
	logic [`LINK_SYNC_BITS-1:0]  sync_reg;
	logic [`LINK_CNT_BITS-1:0]   bit_cnt;

	////////////////////////////////////////////////////////////////////////////
	// sync search
	////////////////////////////////////////////////////////////////////////////

	// listen flag, set by the first start and kept
	always_ff @(posedge clk, negedge rst_l) begin
		if (!rst_l) begin
			listen <= 1'b0;
		end else if (start) begin
			listen <= 1'b1;
		end
	end

	assign synced     = (sync_reg == `LINK_SYNCWORD);
	assign sync_shift = listen & !synced;

	// start clears to zero
	// zero never matches the syncword
	always_ff @(posedge clk, negedge rst_l) begin
		if (!rst_l) begin
			sync_reg <= '0;
		end else if (start) begin
			sync_reg <= '0;
		end else if (sync_shift) begin
			sync_reg <= {sync_reg[`LINK_SYNC_BITS-2:0], serial};
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// packet shift and bit count
	////////////////////////////////////////////////////////////////////////////

	// stops once the full packet is in
	assign data_shift = synced & !done;

	always_ff @(posedge clk, negedge rst_l) begin
		if (!rst_l) begin
			pkt <= '0;
		end else if (start) begin
			pkt <= '0;
		end else if (data_shift) begin
			pkt <= {pkt[`LINK_PKT_BITS-2:0], serial};
		end
	end

	always_ff @(posedge clk, negedge rst_l) begin
		if (!rst_l) begin
			bit_cnt <= '0;
		end else if (start) begin
			bit_cnt <= '0;
		end else if (data_shift) begin
			bit_cnt <= bit_cnt + 1'b1;
		end
	end

	// high right after the edge that takes the last data bit
	assign done = (bit_cnt == `LINK_CNT_BITS'(`LINK_PKT_BITS));

	////////////////////////////////////////////////////////////////////////////
	// checks
	////////////////////////////////////////////////////////////////////////////

	// a packet completes exactly one packet width behind the syncword match
	a_done_after_sync: assert property (@(posedge clk) disable iff (!rst_l)
		$rose(done) |-> synced && $past(synced, `LINK_PKT_BITS) &&
			!$past(synced, `LINK_PKT_BITS + 1));

	// held packet stays put until the updater re-arms the lane
	a_pkt_held: assert property (@(posedge clk) disable iff (!rst_l)
		(done && !start) |=> $stable(pkt));

endmodule : packet_receiver

//--- tb.f
+incdir+rtl
rtl/net_pkg.sv
rtl/disp_pkg.sv
rtl/packet_receiver.sv
rtl/display_updater.sv
rtl/display_link_top.sv
dv/tb_display_link.sv
